// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module spartEchoTb -Mdir obj_dir -o spartEchoSim
./obj_dir/spartEchoSim > sim.log
cat sim.log

if grep -q "RESULT: PASS" sim.log; then
	exit 0
else
	exit 1
fi

// ==== sim.f ====
verilog/spartPkg.sv
verilog/spartDriver.sv
verilog/baudGen.sv
verilog/busInterface.sv
verilog/spartRx.sv
verilog/spartTx.sv
verilog/spartEcho.sv
verif/spartEchoTb.sv

// ==== verif/spartEchoTb.sv ====
`timescale 1ns/1ps

module spartEchoTb;

	import spartPkg::*;

	localparam int clkHz = 100000000;
	localparam int numRows = 13;

	logic clk;
	logic rst;
	logic [1:0] brCfg;
	logic rxd;
	logic txd;

	// Stimulus table, one row per byte on rxd
	logic [1:0] rowCfg [numRows];
	logic [7:0] rowData [numRows];
	bit rowGood [numRows];
	bit rowB2b [numRows];
	bit rowRand [numRows];

	int errors;
	bit aborted;
	int seed;

	spartEcho #(
		.sysClkHz(clkHz)
	) i_dut (
		.clk(clk),
		.rst(rst),
		.brCfg(brCfg),
		.rxd(rxd),
		.txd(txd)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////
	// Reference rules
	//////////////////////////////////////////////////////////////

	// Baud doubles with each brCfg step from 4800
	function automatic int divFor(input logic [1:0] cfg);
		int baud;
		baud = 4800 << cfg;
		return clkHz / (16 * baud) - 1;
	endfunction

	// Bits held low from the start of a frame, start bit included
	function automatic int lowBitsAtStart(input logic [7:0] d);
		int n;
		int k;
		n = 1;
		k = 0;
		while (k < 8 && ((d >> k) & 8'h01) == 8'h00) begin
			n++;
			k++;
		end
		return n;
	endfunction

	task automatic setRow(input int idx, input logic [1:0] cfg, input logic [7:0] data,
			input bit good, input bit b2b, input bit rnd);
		rowCfg[idx]  = cfg;
		rowData[idx] = data;
		rowGood[idx] = good;
		rowB2b[idx]  = b2b;
		rowRand[idx] = rnd;
	endtask

	task automatic checkValue(input string name, input int expected, input int actual,
			input int tol);
		int diff;
		diff = actual - expected;
		if (diff < 0) begin
			diff = -diff;
		end
		if (diff > tol) begin
			$display("Fail at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
			errors++;
		end
	endtask

	//////////////////////////////////////////////////////////////
	// Serial line tasks
	//////////////////////////////////////////////////////////////

	// New baud selector only takes effect through a reset
	task automatic resetDut(input logic [1:0] cfg);
		int k;
		@(posedge clk);
		brCfg <= cfg;
		rst   <= 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		// Line stays idle while the driver configures
		for (k = 0; k < 50; k++) begin
			@(negedge clk);
			checkValue("txd", 1, int'(txd), 0);
		end
	endtask

	task automatic sendFrame(input logic [7:0] data, input bit goodStop, input int bitCycles);
		logic [9:0] frame;
		int k;
		int c;
		int lowPart;
		frame = {goodStop, data, 1'b0};
		for (k = 0; k < 10; k++) begin
			// Bad stop bit spans the mid-bit sample, then the line idles
			lowPart = (k == 9 && !goodStop) ? (bitCycles * 3) / 4 : bitCycles;
			for (c = 0; c < bitCycles; c++) begin
				@(posedge clk);
				rxd <= (c < lowPart) ? frame[0] : 1'b1;
			end
			frame = frame >> 1;
		end
	endtask

	task automatic captureFrame(input int bitCycles, input int waitLimit,
			output logic [7:0] data, output int startLen, output bit ok);
		logic [9:0] bits;
		int waitCnt;
		int t;
		int lowRun;
		int lastSample;
		bit rose;
		ok = 1'b0;
		data = '0;
		startLen = 0;
		bits = '0;
		waitCnt = 0;
		lowRun = 0;
		rose = 1'b0;
		lastSample = 9 * bitCycles + bitCycles / 2;
		@(negedge clk);
		while (txd !== 1'b0 && waitCnt < waitLimit) begin
			@(negedge clk);
			waitCnt++;
		end
		if (txd !== 1'b0) begin
			$display("Timeout at %0t: no start bit on txd within %0d cycles", $time, waitLimit);
			errors++;
			return;
		end
		// t counts cycles from the falling edge of the start bit
		for (t = 0; t <= lastSample; t++) begin
			if (t > 0) begin
				@(negedge clk);
			end
			if (!rose && txd === 1'b1) begin
				rose = 1'b1;
				lowRun = t;
			end
			// Mid-bit samples, start first, stop ends up in the MSB
			if (t % bitCycles == bitCycles / 2) begin
				bits = {txd, bits[9:1]};
			end
		end
		if (!rose) begin
			lowRun = lastSample + 1;
		end
		data = bits[8:1];
		checkValue("txd stop bit", 1, int'(bits[9]), 0);
		startLen = lowRun / lowBitsAtStart(data);
		ok = 1'b1;
	endtask

	task automatic expectQuiet(input int cycles);
		int k;
		bit seen;
		seen = 1'b0;
		for (k = 0; k < cycles && !seen; k++) begin
			@(negedge clk);
			if (txd === 1'b0) begin
				seen = 1'b1;
			end
		end
		if (seen) begin
			$display("Error at %0t: txd sent a frame after a bad stop bit", $time);
			errors++;
		end
	endtask

	//////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////
	initial begin
		int i;
		int step;
		int div;
		int bitCycles;
		logic [1:0] curCfg;
		logic [7:0] gotA;
		logic [7:0] gotB;
		int lenA;
		int lenB;
		bit okA;
		bit okB;
		driverStateT drvState;
		errors = 0;
		aborted = 1'b0;
		seed = 32'h1649;
		rst = 1'b1;
		rxd = 1'b1;
		brCfg = 2'd3;

		// brCfg, byte, good stop, back to back with next row, random byte
		setRow(0, 2'd3, 8'h00, 1'b1, 1'b0, 1'b0);
		setRow(1, 2'd3, 8'hFF, 1'b1, 1'b0, 1'b0);
		setRow(2, 2'd3, 8'h55, 1'b1, 1'b0, 1'b0);
		setRow(3, 2'd3, 8'h00, 1'b0, 1'b0, 1'b1);
		setRow(4, 2'd3, 8'h00, 1'b1, 1'b0, 1'b1);
		setRow(5, 2'd3, 8'h00, 1'b1, 1'b1, 1'b1);
		setRow(6, 2'd3, 8'h00, 1'b1, 1'b0, 1'b1);
		setRow(7, 2'd2, 8'h55, 1'b1, 1'b0, 1'b0);
		setRow(8, 2'd2, 8'h00, 1'b1, 1'b0, 1'b1);
		setRow(9, 2'd1, 8'hFF, 1'b1, 1'b0, 1'b0);
		setRow(10, 2'd1, 8'h00, 1'b1, 1'b0, 1'b1);
		setRow(11, 2'd0, 8'h00, 1'b1, 1'b0, 1'b0);
		setRow(12, 2'd0, 8'h00, 1'b1, 1'b0, 1'b1);
		for (i = 0; i < numRows; i++) begin
			if (rowRand[i]) begin
				rowData[i] = 8'($random(seed));
			end
		end

		curCfg = rowCfg[0];
		resetDut(curCfg);
		i = 0;
		while (i < numRows && !aborted) begin
			if (rowCfg[i] != curCfg) begin
				curCfg = rowCfg[i];
				resetDut(curCfg);
			end
			div = divFor(curCfg);
			bitCycles = overSample * (div + 1);
			drvState = i_dut.i_driver.state;
			$display("Row %0d: brCfg %0d byte 0x%02h driver %s", i, curCfg, rowData[i],
				drvState.name());
			step = rowB2b[i] ? 2 : 1;
			if (!rowGood[i]) begin
				// Three frame times of silence expected on txd
				sendFrame(rowData[i], 1'b0, bitCycles);
				expectQuiet(30 * bitCycles);
			end else begin
				okA = 1'b1;
				okB = 1'b1;
				fork
					begin
						sendFrame(rowData[i], 1'b1, bitCycles);
						if (rowB2b[i]) begin
							sendFrame(rowData[i + 1], 1'b1, bitCycles);
						end
					end
					begin
						captureFrame(bitCycles, 25 * bitCycles, gotA, lenA, okA);
						if (okA && rowB2b[i]) begin
							captureFrame(bitCycles, 25 * bitCycles, gotB, lenB, okB);
						end
					end
				join
				if (okA) begin
					checkValue("echo byte", int'(rowData[i]), int'(gotA), 0);
					checkValue("start bit cycles", bitCycles, lenA, div + 1);
				end
				if (okA && okB && rowB2b[i]) begin
					checkValue("echo byte", int'(rowData[i + 1]), int'(gotB), 0);
					checkValue("start bit cycles", bitCycles, lenB, div + 1);
				end
				aborted = !okA || !okB;
			end
			i += step;
			// Idle gap before the next row
			repeat (2 * bitCycles) @(posedge clk);
		end

		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== verilog/baudGen.sv ====
`timescale 1ns/1ps

module baudGen (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [spartPkg::divWidth-1:0] divisor,
	output logic                          tick
);

	import spartPkg::*;

	logic [divWidth-1:0] count;
	logic [divWidth-1:0] divPrev;
	logic divChanged;

	// Fresh divisor forces a reload
	assign divChanged = (divisor != divPrev);

	// One pulse per divisor + 1 cycles
	assign tick = (count == '0);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			count   <= '0;
			divPrev <= '0;
		end else begin
			divPrev <= divisor;
			if (divChanged || count == '0) begin
				// Restart from the full value
				count <= divisor;
			end else begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// ==== verilog/busInterface.sv ====
`timescale 1ns/1ps

module busInterface (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          iocs,
	input  logic                          iorw,
	input  spartPkg::ioAddrT              ioaddr,
	input  logic [spartPkg::busWidth-1:0] busWrData,
	input  logic [spartPkg::busWidth-1:0] rxData,
	input  logic                          rda,
	input  logic                          tbr,
	output logic [spartPkg::busWidth-1:0] busRdData,
	output logic [spartPkg::divWidth-1:0] divisor,
	output logic                          txLoad,
	output logic [spartPkg::busWidth-1:0] txData,
	output logic                          rxAck
);

	import spartPkg::*;

	// 38400 baud at 100 MHz
	localparam logic [divWidth-1:0] divReset = divWidth'(100000000 / (overSample * 38400) - 1);

	logic wrAccess;
	logic rdAccess;

	assign wrAccess = iocs && !iorw;
	assign rdAccess = iocs && iorw;

	//////////////////////////////////////////////////////////////
	// Write side
	//////////////////////////////////////////////////////////////

	// Tx write dropped while the buffer is busy
	assign txLoad = wrAccess && (ioaddr == dataReg) && tbr;
	assign txData = busWrData;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			divisor <= divReset;
		end else if (wrAccess && ioaddr == divLowReg) begin
			divisor[busWidth-1:0] <= busWrData;
		end else if (wrAccess && ioaddr == divHighReg) begin
			divisor[divWidth-1:busWidth] <= busWrData;
		end
	end

	//////////////////////////////////////////////////////////////
	// Read side
	//////////////////////////////////////////////////////////////

	// Reading the rx buffer releases rda
	assign rxAck = rdAccess && (ioaddr == dataReg);

	always_comb begin
		case (ioaddr)
			dataReg:   busRdData = rxData;
			// Bit 1 rda, bit 0 tbr
			statusReg: busRdData = {{(busWidth - 2){1'b0}}, rda, tbr};
			default:   busRdData = '0;
		endcase
	end

endmodule

// ==== verilog/spartDriver.sv ====
`timescale 1ns/1ps

module spartDriver #(
	parameter int sysClkHz = 100000000
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [1:0]                     brCfg,
	input  logic                           rda,
	input  logic                           tbr,
	input  logic [spartPkg::busWidth-1:0]  busRdData,
	output logic                           iocs,
	output logic                           iorw,
	output spartPkg::ioAddrT               ioaddr,
	output logic [spartPkg::busWidth-1:0]  busWrData
);

	import spartPkg::*;

	// Divisor per baud selector, rounded down
	localparam logic [divWidth-1:0] div4800  = divWidth'(sysClkHz / (overSample * 4800) - 1);
	localparam logic [divWidth-1:0] div9600  = divWidth'(sysClkHz / (overSample * 9600) - 1);
	localparam logic [divWidth-1:0] div19200 = divWidth'(sysClkHz / (overSample * 19200) - 1);
	localparam logic [divWidth-1:0] div38400 = divWidth'(sysClkHz / (overSample * 38400) - 1);

	driverStateT state;
	driverStateT nextState;
	logic [divWidth-1:0] cfgDiv;
	logic [busWidth-1:0] heldByte;

	// Baud selector picks the divisor for the config writes
	always_comb begin
		case (brCfg)
			2'd0:    cfgDiv = div4800;
			2'd1:    cfgDiv = div9600;
			2'd2:    cfgDiv = div19200;
			default: cfgDiv = div38400;
		endcase
	end

	//////////////////////////////////////////////////////////////
	// Bus outputs and next state
	//////////////////////////////////////////////////////////////
	always_comb begin
		nextState = state;
		iocs      = 1'b0;
		iorw      = 1'b1;
		ioaddr    = dataReg;
		busWrData = heldByte;
		case (state)
			cfgLow: begin
				iocs      = 1'b1;
				iorw      = 1'b0;
				ioaddr    = divLowReg;
				busWrData = cfgDiv[busWidth-1:0];
				nextState = cfgHigh;
			end
			cfgHigh: begin
				iocs      = 1'b1;
				iorw      = 1'b0;
				ioaddr    = divHighReg;
				busWrData = cfgDiv[divWidth-1:busWidth];
				nextState = idle;
			end
			idle: begin
				// Read the rx buffer as soon as a byte shows up
				if (rda) begin
					iocs      = 1'b1;
					nextState = proc;
				end
			end
			proc: begin
				// Hold here until the transmitter can take the byte
				if (tbr) begin
					iocs      = 1'b1;
					iorw      = 1'b0;
					nextState = idle;
				end
			end
			default: nextState = cfgLow;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= cfgLow;
		end else begin
			state <= nextState;
		end
	end

	// Byte captured on the echo read
	always_ff @(posedge clk) begin
		if (state == idle && rda) begin
			heldByte <= busRdData;
		end
	end

endmodule

// ==== verilog/spartEcho.sv ====
`timescale 1ns/1ps

module spartEcho #(
	parameter int sysClkHz = 100000000
) (
	input  logic       clk,
	input  logic       rst,
	input  logic [1:0] brCfg,
	input  logic       rxd,
	output logic       txd
);

	import spartPkg::*;

	// Processor side bus
	logic iocs;
	logic iorw;
	ioAddrT ioaddr;
	logic [busWidth-1:0] busWrData;
	logic [busWidth-1:0] busRdData;

	// Flags seen by both driver and status register
	logic rda;
	logic tbr;

	// SPART internals
	logic [divWidth-1:0] divisor;
	logic tick;
	logic txLoad;
	logic [busWidth-1:0] txData;
	logic rxAck;
	logic [busWidth-1:0] rxData;

	//////////////////////////////////////////////////////////////
	// Driver
	//////////////////////////////////////////////////////////////
	spartDriver #(
		.sysClkHz(sysClkHz)
	) i_driver (
		.clk(clk),
		.rst(rst),
		.brCfg(brCfg),
		.rda(rda),
		.tbr(tbr),
		.busRdData(busRdData),
		.iocs(iocs),
		.iorw(iorw),
		.ioaddr(ioaddr),
		.busWrData(busWrData)
	);

	//////////////////////////////////////////////////////////////
	// SPART
	//////////////////////////////////////////////////////////////
	busInterface i_bus (
		.clk(clk),
		.rst(rst),
		.iocs(iocs),
		.iorw(iorw),
		.ioaddr(ioaddr),
		.busWrData(busWrData),
		.rxData(rxData),
		.rda(rda),
		.tbr(tbr),
		.busRdData(busRdData),
		.divisor(divisor),
		.txLoad(txLoad),
		.txData(txData),
		.rxAck(rxAck)
	);

	baudGen i_baud (
		.clk(clk),
		.rst(rst),
		.divisor(divisor),
		.tick(tick)
	);

	spartRx i_rx (
		.clk(clk),
		.rst(rst),
		.tick(tick),
		.rxd(rxd),
		.rxAck(rxAck),
		.rxData(rxData),
		.rda(rda)
	);

	spartTx i_tx (
		.clk(clk),
		.rst(rst),
		.tick(tick),
		.txLoad(txLoad),
		.txData(txData),
		.txd(txd),
		.tbr(tbr)
	);

endmodule

// ==== verilog/spartPkg.sv ====
package spartPkg;

	//////////////////////////////////////////////////////////////
	// Register map as seen from the processor side
	//////////////////////////////////////////////////////////////

	// Data register doubles as tx buffer (write) and rx buffer (read)
	typedef enum logic [1:0] {
		dataReg    = 2'd0,
		statusReg  = 2'd1,
		divLowReg  = 2'd2,
		divHighReg = 2'd3
	} ioAddrT;

	//////////////////////////////////////////////////////////////
	// Driver FSM
	//////////////////////////////////////////////////////////////

	// Two config cycles, then the echo loop
	typedef enum logic [1:0] {
		cfgLow  = 2'd0,
		cfgHigh = 2'd1,
		idle    = 2'd2,
		proc    = 2'd3
	} driverStateT;

	// Data bus width
	localparam int busWidth = 8;

	// Baud divisor width, two bus writes
	localparam int divWidth = 16;

	// Baud ticks per serial bit
	localparam int overSample = 16;

endpackage

// ==== verilog/spartRx.sv ====
`timescale 1ns/1ps

module spartRx (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          tick,
	input  logic                          rxd,
	input  logic                          rxAck,
	output logic [spartPkg::busWidth-1:0] rxData,
	output logic                          rda
);

	import spartPkg::*;

	localparam int cntWidth = $clog2(overSample);
	localparam logic [cntWidth-1:0] halfBit = cntWidth'(overSample / 2 - 1);
	localparam logic [cntWidth-1:0] lastTick = cntWidth'(overSample - 1);

	typedef enum logic [1:0] {stIdle, stStart, stData, stStop} rxStateT;

	rxStateT state;
	logic rxSync1;
	logic rxSync2;
	logic [cntWidth-1:0] tickCnt;
	logic [2:0] bitCnt;
	logic [busWidth-1:0] shiftReg;
	logic bitEnd;
	logic stopGood;

	// Two flop synchronizer, idles high like the line
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rxSync1 <= 1'b1;
			rxSync2 <= 1'b1;
		end else begin
			rxSync1 <= rxd;
			rxSync2 <= rxSync1;
		end
	end

	// Mid-bit sample point of a data or stop bit
	assign bitEnd = tick && (tickCnt == lastTick);
	assign stopGood = (state == stStop) && bitEnd && rxSync2;

	//////////////////////////////////////////////////////////////
	// Frame FSM
	//////////////////////////////////////////////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state   <= stIdle;
			tickCnt <= '0;
			bitCnt  <= '0;
		end else begin
			case (state)
				stIdle: begin
					// Falling edge of a start bit
					if (!rxSync2) begin
						state   <= stStart;
						tickCnt <= '0;
					end
				end
				stStart: begin
					if (tick && tickCnt == halfBit) begin
						// Glitch if the line is back high by mid-bit
						state   <= rxSync2 ? stIdle : stData;
						tickCnt <= '0;
						bitCnt  <= '0;
					end else if (tick) begin
						tickCnt <= tickCnt + 1'b1;
					end
				end
				stData: begin
					if (bitEnd) begin
						tickCnt <= '0;
						bitCnt  <= bitCnt + 1'b1;
						if (bitCnt == 3'd7) begin
							state <= stStop;
						end
					end else if (tick) begin
						tickCnt <= tickCnt + 1'b1;
					end
				end
				stStop: begin
					// Back to idle at mid stop bit, bad frames just vanish
					if (bitEnd) begin
						state   <= stIdle;
						tickCnt <= '0;
					end else if (tick) begin
						tickCnt <= tickCnt + 1'b1;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	// LSB arrives first
	always_ff @(posedge clk) begin
		if (state == stData && bitEnd) begin
			shiftReg <= {rxSync2, shiftReg[busWidth-1:1]};
		end
		if (stopGood) begin
			rxData <= shiftReg;
		end
	end

	// New frame wins over a same-cycle read
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rda <= 1'b0;
		end else if (stopGood) begin
			rda <= 1'b1;
		end else if (rxAck) begin
			rda <= 1'b0;
		end
	end

endmodule

// ==== verilog/spartTx.sv ====
`timescale 1ns/1ps

module spartTx (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          tick,
	input  logic                          txLoad,
	input  logic [spartPkg::busWidth-1:0] txData,
	output logic                          txd,
	output logic                          tbr
);

	import spartPkg::*;

	localparam int cntWidth = $clog2(overSample);
	localparam logic [cntWidth-1:0] lastTick = cntWidth'(overSample - 1);

	typedef enum logic [1:0] {stIdle, stWait, stSend} txStateT;

	txStateT state;
	logic [cntWidth-1:0] tickCnt;
	logic [3:0] bitCnt;
	// Stop, data, start from MSB down
	logic [busWidth+1:0] frame;

	// Buffer free only when nothing is queued or on the line
	assign tbr = (state == stIdle);

	always_ff @(posedge clk) begin
		if (txLoad && state == stIdle) begin
			frame <= {1'b1, txData, 1'b0};
		end else if (tick && (state == stWait || tickCnt == lastTick)) begin
			// Shift in ones so the line ends idle
			frame <= {1'b1, frame[busWidth+1:1]};
		end
	end

	//////////////////////////////////////////////////////////////
	// Bit timing
	//////////////////////////////////////////////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state   <= stIdle;
			txd     <= 1'b1;
			tickCnt <= '0;
			bitCnt  <= '0;
		end else begin
			case (state)
				stIdle: begin
					if (txLoad) begin
						state <= stWait;
					end
				end
				stWait: begin
					// Start bit lines up with the next tick
					if (tick) begin
						state   <= stSend;
						txd     <= frame[0];
						tickCnt <= '0;
						bitCnt  <= '0;
					end
				end
				stSend: begin
					if (tick && tickCnt == lastTick) begin
						tickCnt <= '0;
						if (bitCnt == 4'd9) begin
							// Last tick of the stop bit
							state <= stIdle;
							txd   <= 1'b1;
						end else begin
							txd    <= frame[0];
							bitCnt <= bitCnt + 1'b1;
						end
					end else if (tick) begin
						tickCnt <= tickCnt + 1'b1;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

endmodule
